/* src/rx_pcs_defines.svh */
// =========================================================================
// Width, descrambler and block lock constants of the 64b/66b receive PCS
// Included by the package and by each module that sizes logic from them
// =========================================================================

`ifndef RX_PCS_DEFINES_SVH
`define RX_PCS_DEFINES_SVH

// Transceiver word, bit 0 received first
`define PCS_GT_WIDTH        32

// A 66-bit block is sync header plus payload
`define PCS_PAYLOAD_WIDTH   64
`define PCS_HEADER_WIDTH    2

// Descrambler polynomial x^58 + x^39 + 1
`define PCS_SCR_TAP_A       58
`define PCS_SCR_TAP_B       39

// Headers per window, also the clean run needed for lock
`define PCS_LOCK_COUNT      64
// Invalid headers in one window that drop lock
`define PCS_BAD_LIMIT       16

`endif

/* src/rx_pcs_pkg.sv */
// =========================================================================
// Shared types of the receive PCS, used by the RTL and the testbench
// Always referenced with the rx_pcs_pkg:: scope
// =========================================================================

`include "rx_pcs_defines.svh"

package rx_pcs_pkg;

  // One transceiver word, bit 0 is first on the line
  typedef logic [`PCS_GT_WIDTH-1:0] gt_word_t;

  // Sync header codes
  // First received header bit sits in the LSB
  typedef enum logic [`PCS_HEADER_WIDTH-1:0] {
    SH_BAD0 = 2'b00,
    SH_DATA = 2'b01,
    SH_CTRL = 2'b10,
    SH_BAD3 = 2'b11
  } sync_header_e;

  // Block as rebuilt by the gearbox, payload still scrambled
  typedef struct packed {
    logic [`PCS_HEADER_WIDTH-1:0]  header;
    logic [`PCS_PAYLOAD_WIDTH-1:0] payload;
  } raw_block_t;

  // Classification of a received block
  typedef enum logic [1:0] {
    KIND_DATA  = 2'd0,
    KIND_CTRL  = 2'd1,
    KIND_ERROR = 2'd2
  } block_kind_e;

  // Block as delivered at the top level, payload descrambled
  typedef struct packed {
    block_kind_e                   kind;
    logic [`PCS_PAYLOAD_WIDTH-1:0] payload;
  } rx_block_t;

  // Block lock FSM states
  typedef enum logic [1:0] {
    LOCK_INIT = 2'd0,
    LOCK_TEST = 2'd1,
    LOCK_SLIP = 2'd2,
    LOCK_GOOD = 2'd3
  } lock_state_e;

endpackage

/* src/rx_gearbox.sv */
// =========================================================================
// 32-to-66 receive gearbox
// Collects transceiver words in a bit buffer and emits one block whenever
// 66 bits are present; a slip drops the oldest bit to shift the boundary
// =========================================================================

`include "rx_pcs_defines.svh"

module rx_gearbox (
  input  logic                   gt0_rxusrclk2_i,
  input  logic                   gt0_rxfsmresetdone_i,
  input  rx_pcs_pkg::gt_word_t   gt_word_i,
  input  logic                   slip_i,
  output rx_pcs_pkg::raw_block_t raw_block_o,
  output logic                   block_valid_o
);

  // =========================================================================
  // Sizes
  // =========================================================================

  localparam int GT_W    = `PCS_GT_WIDTH;
  localparam int BLOCK_W = `PCS_HEADER_WIDTH + `PCS_PAYLOAD_WIDTH;
  // At most 65 leftover bits plus one new word
  localparam int BUF_W   = BLOCK_W - 1 + GT_W;
  localparam int FILL_W  = $clog2(BUF_W + 1);

  // Bit 0 of the buffer is the oldest received bit
  logic [BUF_W-1:0]  bit_buf;
  logic [FILL_W-1:0] fill;

  // Buffer after this cycle's word and slip
  logic [BUF_W-1:0]  wide_word;
  logic [BUF_W-1:0]  joined_buf;
  logic [FILL_W-1:0] joined_fill;
  logic              block_ready;

  // =========================================================================
  // Append and slip
  // =========================================================================

  assign wide_word = {{(BUF_W-GT_W){1'b0}}, gt_word_i};

  always_comb begin
    // New word lands right above the buffered bits
    joined_buf  = bit_buf | (wide_word << fill);
    joined_fill = fill + FILL_W'(GT_W);
    // Slip drops the oldest bit
    // The joined buffer always holds a full word, so there is a bit to drop
    if (slip_i) begin
      joined_buf  = joined_buf >> 1;
      joined_fill = joined_fill - 1'b1;
    end
    block_ready = joined_fill >= FILL_W'(BLOCK_W);
  end

  // =========================================================================
  // Buffer and block registers
  // =========================================================================

  always_ff @(posedge gt0_rxusrclk2_i or negedge gt0_rxfsmresetdone_i) begin
    if (!gt0_rxfsmresetdone_i) begin
      bit_buf       <= '0;
      fill          <= '0;
      block_valid_o <= 1'b0;
    end else begin
      // Valid one cycle after the word that completes a block
      block_valid_o <= block_ready;
      if (block_ready) begin
        // Keep only the bits past the emitted block
        bit_buf <= joined_buf >> BLOCK_W;
        fill    <= joined_fill - FILL_W'(BLOCK_W);
      end else begin
        bit_buf <= joined_buf;
        fill    <= joined_fill;
      end
    end
  end

  // Header takes the first two received bits, payload the next 64
  always_ff @(posedge gt0_rxusrclk2_i) begin
    if (block_ready) begin
      raw_block_o.header  <= joined_buf[`PCS_HEADER_WIDTH-1:0];
      raw_block_o.payload <= joined_buf[BLOCK_W-1:`PCS_HEADER_WIDTH];
    end
  end

endmodule

/* src/sh_window_counter.sv */
// =========================================================================
// Sync header window counter
// Counts tested and invalid headers in the current window and flags a
// completed window or a reached invalid limit one cycle after the test
// =========================================================================

`include "rx_pcs_defines.svh"

module sh_window_counter (
  input  logic gt0_rxusrclk2_i,
  input  logic gt0_rxfsmresetdone_i,
  input  logic clear_i,
  input  logic test_i,
  input  logic header_valid_i,
  output logic window_done_o,
  output logic bad_limit_hit_o
);

  localparam int TEST_W = $clog2(`PCS_LOCK_COUNT + 1);
  localparam int BAD_W  = $clog2(`PCS_BAD_LIMIT + 1);

  logic [TEST_W-1:0] test_cnt;
  logic [BAD_W-1:0]  bad_cnt;
  logic [TEST_W-1:0] test_cnt_nxt;
  logic [BAD_W-1:0]  bad_cnt_nxt;
  logic              window_end;
  logic              limit_reached;

  // Counts after the current test
  always_comb begin
    test_cnt_nxt = test_cnt + 1'b1;
    bad_cnt_nxt  = bad_cnt;
    // Invalid count saturates at the limit
    if (!header_valid_i && (bad_cnt != BAD_W'(`PCS_BAD_LIMIT))) begin
      bad_cnt_nxt = bad_cnt + 1'b1;
    end
    window_end    = test_cnt_nxt == TEST_W'(`PCS_LOCK_COUNT);
    limit_reached = bad_cnt_nxt == BAD_W'(`PCS_BAD_LIMIT);
  end

  always_ff @(posedge gt0_rxusrclk2_i or negedge gt0_rxfsmresetdone_i) begin
    if (!gt0_rxfsmresetdone_i) begin
      test_cnt        <= '0;
      bad_cnt         <= '0;
      window_done_o   <= 1'b0;
      bad_limit_hit_o <= 1'b0;
    end else begin
      // Flags are single-cycle
      window_done_o   <= 1'b0;
      bad_limit_hit_o <= 1'b0;
      if (clear_i) begin
        test_cnt <= '0;
        bad_cnt  <= '0;
      end else if (test_i) begin
        window_done_o   <= window_end;
        bad_limit_hit_o <= limit_reached;
        // A full window starts the next one from zero
        if (window_end) begin
          test_cnt <= '0;
          bad_cnt  <= '0;
        end else begin
          test_cnt <= test_cnt_nxt;
          bad_cnt  <= bad_cnt_nxt;
        end
      end
    end
  end

endmodule

/* src/block_lock_fsm.sv */
// =========================================================================
// Block lock FSM
// Tests each sync header, requests gearbox slips while unaligned, and
// holds block lock until too many invalid headers fall in one window
// =========================================================================

module block_lock_fsm (
  input  logic                   gt0_rxusrclk2_i,
  input  logic                   gt0_rxfsmresetdone_i,
  input  rx_pcs_pkg::raw_block_t raw_block_i,
  input  logic                   block_valid_i,
  input  logic                   window_done_i,
  input  logic                   bad_limit_hit_i,
  output logic                   test_o,
  output logic                   header_valid_o,
  output logic                   clear_o,
  output logic                   slip_o,
  output logic                   block_lock_o
);

  rx_pcs_pkg::lock_state_e  state;
  rx_pcs_pkg::lock_state_e  state_nxt;
  rx_pcs_pkg::sync_header_e header;

  // =========================================================================
  // Header test
  // =========================================================================

  assign header = rx_pcs_pkg::sync_header_e'(raw_block_i.header);

  // Only 01 and 10 are legal headers
  assign header_valid_o = (header == rx_pcs_pkg::SH_DATA) ||
                          (header == rx_pcs_pkg::SH_CTRL);

  // Block seen in the slip cycle still has the old alignment
  assign test_o = block_valid_i && (state != rx_pcs_pkg::LOCK_SLIP);

  // =========================================================================
  // State machine
  // =========================================================================

  always_comb begin
    state_nxt = state;
    case (state)
      // Fresh alignment, waiting for the first header
      rx_pcs_pkg::LOCK_INIT: begin
        if (test_o) begin
          state_nxt = header_valid_o ? rx_pcs_pkg::LOCK_TEST : rx_pcs_pkg::LOCK_SLIP;
        end
      end
      // Unlocked, any bad header slips
      // Window flag lands one cycle after its last test
      rx_pcs_pkg::LOCK_TEST: begin
        if (test_o && !header_valid_o) begin
          state_nxt = rx_pcs_pkg::LOCK_SLIP;
        end else if (window_done_i) begin
          state_nxt = rx_pcs_pkg::LOCK_GOOD;
        end
      end
      // One-cycle slip request
      rx_pcs_pkg::LOCK_SLIP: begin
        state_nxt = rx_pcs_pkg::LOCK_INIT;
      end
      // Locked, only the window limit costs lock
      rx_pcs_pkg::LOCK_GOOD: begin
        if (bad_limit_hit_i) begin
          state_nxt = rx_pcs_pkg::LOCK_SLIP;
        end
      end
      default: begin
        state_nxt = rx_pcs_pkg::LOCK_INIT;
      end
    endcase
  end

  always_ff @(posedge gt0_rxusrclk2_i or negedge gt0_rxfsmresetdone_i) begin
    if (!gt0_rxfsmresetdone_i) begin
      state <= rx_pcs_pkg::LOCK_INIT;
    end else begin
      state <= state_nxt;
    end
  end

  // =========================================================================
  // Outputs
  // =========================================================================

  // Counts restart as soon as a slip is decided
  assign clear_o      = (state_nxt == rx_pcs_pkg::LOCK_SLIP) &&
                        (state != rx_pcs_pkg::LOCK_SLIP);
  assign slip_o       = state == rx_pcs_pkg::LOCK_SLIP;
  assign block_lock_o = state == rx_pcs_pkg::LOCK_GOOD;

endmodule

/* src/rx_descrambler.sv */
// =========================================================================
// Self-synchronizing descrambler and block classifier
// Runs on every block so the history stays current, and presents a
// registered block only while block lock is held
// =========================================================================

`include "rx_pcs_defines.svh"

module rx_descrambler (
  input  logic                   gt0_rxusrclk2_i,
  input  logic                   gt0_rxfsmresetdone_i,
  input  rx_pcs_pkg::raw_block_t raw_block_i,
  input  logic                   block_valid_i,
  input  logic                   block_lock_i,
  output rx_pcs_pkg::rx_block_t  rx_block_o,
  output logic                   rx_valid_o
);

  localparam int PAY_W   = `PCS_PAYLOAD_WIDTH;
  localparam int HIST_W  = `PCS_SCR_TAP_A;
  localparam int TAP_GAP = `PCS_SCR_TAP_A - `PCS_SCR_TAP_B;

  // Last 58 received bits, MSB is the most recent one
  logic [HIST_W-1:0]       scr_state;
  // History followed by the new payload, in receive order from bit 0
  logic [PAY_W+HIST_W-1:0] line_bits;
  logic [PAY_W-1:0]        plain;
  rx_pcs_pkg::sync_header_e header;
  rx_pcs_pkg::block_kind_e  kind;

  // =========================================================================
  // Descramble
  // =========================================================================

  assign line_bits = {raw_block_i.payload, scr_state};

  // Each bit XOR the bits 39 and 58 positions earlier
  always_comb begin
    for (int i = 0; i < PAY_W; i++) begin
      plain[i] = line_bits[HIST_W + i] ^ line_bits[TAP_GAP + i] ^ line_bits[i];
    end
  end

  // =========================================================================
  // Classify
  // =========================================================================

  assign header = rx_pcs_pkg::sync_header_e'(raw_block_i.header);

  always_comb begin
    case (header)
      rx_pcs_pkg::SH_DATA: kind = rx_pcs_pkg::KIND_DATA;
      rx_pcs_pkg::SH_CTRL: kind = rx_pcs_pkg::KIND_CTRL;
      default:             kind = rx_pcs_pkg::KIND_ERROR;
    endcase
  end

  // =========================================================================
  // Registers
  // =========================================================================

  always_ff @(posedge gt0_rxusrclk2_i or negedge gt0_rxfsmresetdone_i) begin
    if (!gt0_rxfsmresetdone_i) begin
      scr_state  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= block_valid_i && block_lock_i;
      // History follows received bits, locked or not
      if (block_valid_i) begin
        scr_state <= raw_block_i.payload[PAY_W-1:PAY_W-HIST_W];
      end
    end
  end

  always_ff @(posedge gt0_rxusrclk2_i) begin
    if (block_valid_i) begin
      rx_block_o.kind    <= kind;
      rx_block_o.payload <= plain;
    end
  end

endmodule

/* src/rx_pcs_top.sv */
// =========================================================================
// 64b/66b receive PCS top level
// Gearbox, block lock, header window counter and descrambler on one clock
// Output is valid-only, there is no ready and no back-pressure
// =========================================================================

module rx_pcs_top (
  input  logic                  gt0_rxusrclk2_i,
  input  logic                  gt0_rxfsmresetdone_i,
  input  rx_pcs_pkg::gt_word_t  gt_word_i,
  output rx_pcs_pkg::rx_block_t rx_block_o,
  output logic                  rx_valid_o,
  output logic                  block_lock_o
);

  // =========================================================================
  // Internal wires
  // =========================================================================

  // Gearbox to lock FSM and descrambler
  rx_pcs_pkg::raw_block_t raw_block;
  logic                   block_valid;
  // Lock FSM back to gearbox
  logic                   slip;
  // Lock FSM and window counter
  logic                   clear;
  logic                   test;
  logic                   header_valid;
  logic                   window_done;
  logic                   bad_limit_hit;

  // =========================================================================
  // Instances
  // =========================================================================

  rx_gearbox u_rx_gearbox (
    .gt0_rxusrclk2_i      (gt0_rxusrclk2_i),
    .gt0_rxfsmresetdone_i (gt0_rxfsmresetdone_i),
    .gt_word_i            (gt_word_i),
    .slip_i               (slip),
    .raw_block_o          (raw_block),
    .block_valid_o        (block_valid)
  );

  block_lock_fsm u_block_lock_fsm (
    .gt0_rxusrclk2_i      (gt0_rxusrclk2_i),
    .gt0_rxfsmresetdone_i (gt0_rxfsmresetdone_i),
    .raw_block_i          (raw_block),
    .block_valid_i        (block_valid),
    .window_done_i        (window_done),
    .bad_limit_hit_i      (bad_limit_hit),
    .test_o               (test),
    .header_valid_o       (header_valid),
    .clear_o              (clear),
    .slip_o               (slip),
    .block_lock_o         (block_lock_o)
  );

  sh_window_counter u_sh_window_counter (
    .gt0_rxusrclk2_i      (gt0_rxusrclk2_i),
    .gt0_rxfsmresetdone_i (gt0_rxfsmresetdone_i),
    .clear_i              (clear),
    .test_i               (test),
    .header_valid_i       (header_valid),
    .window_done_o        (window_done),
    .bad_limit_hit_o      (bad_limit_hit)
  );

  // Lock flag also gates the block output
  rx_descrambler u_rx_descrambler (
    .gt0_rxusrclk2_i      (gt0_rxusrclk2_i),
    .gt0_rxfsmresetdone_i (gt0_rxfsmresetdone_i),
    .raw_block_i          (raw_block),
    .block_valid_i        (block_valid),
    .block_lock_i         (block_lock_o),
    .rx_block_o           (rx_block_o),
    .rx_valid_o           (rx_valid_o)
  );

endmodule

/* bench/rx_pcs_chk.sv */
// ==========================================================================
// Concurrent assertions on the block lock FSM
// Bound into every block_lock_fsm instance
// ==========================================================================

module rx_pcs_chk (
  input logic                    gt0_rxusrclk2_i,
  input logic                    gt0_rxfsmresetdone_i,
  input rx_pcs_pkg::lock_state_e state_i,
  input logic                    slip_i,
  input logic                    block_lock_i
);

  // Slip request is a single-cycle pulse
  slip_single: assert property (
    @(posedge gt0_rxusrclk2_i) disable iff (!gt0_rxfsmresetdone_i)
    slip_i |=> !slip_i
  ) else $error("slip_o held for two cycles");

  // Lock stays low during a slip and in the cycle after it
  slip_unlocked: assert property (
    @(posedge gt0_rxusrclk2_i) disable iff (!gt0_rxfsmresetdone_i)
    (slip_i || $past(slip_i)) |-> !block_lock_i
  ) else $error("block_lock_o high during or right after slip_o");

  // Lock is only granted after a test window
  lock_from_test: assert property (
    @(posedge gt0_rxusrclk2_i) disable iff (!gt0_rxfsmresetdone_i)
    $rose(block_lock_i) |-> $past(state_i) == rx_pcs_pkg::LOCK_TEST
  ) else $error("block_lock_o rose from a state other than LOCK_TEST");

  // Quiet outputs in reset
  reset_quiet: assert property (
    @(posedge gt0_rxusrclk2_i)
    !gt0_rxfsmresetdone_i |-> (!slip_i && !block_lock_i)
  ) else $error("FSM outputs high during reset");

endmodule

bind block_lock_fsm rx_pcs_chk u_rx_pcs_chk (
  .gt0_rxusrclk2_i      (gt0_rxusrclk2_i),
  .gt0_rxfsmresetdone_i (gt0_rxfsmresetdone_i),
  .state_i              (state),
  .slip_i               (slip_o),
  .block_lock_i         (block_lock_o)
);

/* bench/rx_pcs_tb.sv */
// ==========================================================================
// Testbench of the 64b/66b receive PCS
// Scrambled random blocks start at a random bit offset. Runs of corrupted
// headers follow, and every locked output is checked in order against a model
// ==========================================================================

`include "rx_pcs_defines.svh"

module rx_pcs_tb;

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 16;
  localparam int ZERO_CYCLES   = 200;
  localparam int BLOCK_W       = `PCS_HEADER_WIDTH + `PCS_PAYLOAD_WIDTH;
  // Worst case to lock, one window per bit position plus one
  localparam int LOCK_WAIT     = (BLOCK_W + 1) * `PCS_LOCK_COUNT;
  localparam int CLEAN_RUN     = 200;
  localparam int SMALL_RUN     = 150;
  localparam int DROP_WAIT     = 200;
  // One short of the invalid count that drops lock
  localparam int SMALL_BAD     = `PCS_BAD_LIMIT - 1;
  localparam int LARGE_BAD     = 40;
  localparam int TOTAL_BLOCKS  = 2 * LOCK_WAIT + 2 * CLEAN_RUN + SMALL_RUN + DROP_WAIT;
  localparam int WATCHDOG_TIME =
    (TOTAL_BLOCKS * 3 + RESET_CYCLES + ZERO_CYCLES + 200) * CLK_PERIOD;

  logic                      gt0_rxusrclk2;
  logic                      gt0_rxfsmresetdone;
  rx_pcs_pkg::gt_word_t      gt_word;
  rx_pcs_pkg::rx_block_t     rx_block;
  logic                      rx_valid;
  logic                      block_lock;

  // Transmit model, line bits are queued oldest first
  logic [31:0]               lcg_state;
  logic [`PCS_SCR_TAP_A-1:0] scr_hist;
  logic                      line_q[$];
  rx_pcs_pkg::rx_block_t     exp_q[$];
  logic [15:0]               seq;
  int                        blocks_gen;
  int                        corrupt_left;
  logic                      stream_on;
  // Monitor state and error counts
  logic                      check_low;
  logic                      expect_lock;
  logic                      aligned;
  logic                      lock_prev;
  int                        checked;
  int                        err_kinds;
  int                        block_errs;
  int                        lock_errs;
  int                        other_errs;

  rx_pcs_top DUT (
    .gt0_rxusrclk2_i      (gt0_rxusrclk2),
    .gt0_rxfsmresetdone_i (gt0_rxfsmresetdone),
    .gt_word_i            (gt_word),
    .rx_block_o           (rx_block),
    .rx_valid_o           (rx_valid),
    .block_lock_o         (block_lock)
  );

  initial begin
    gt0_rxusrclk2 = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      gt0_rxusrclk2 = ~gt0_rxusrclk2;
    end
  end

  // ==========================================================================
  // Stimulus model
  // ==========================================================================

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // One block onto the line, its expected output into the model queue
  task automatic gen_block();
    logic [31:0]                   r_kind;
    logic [31:0]                   r_hi;
    logic [31:0]                   r_lo;
    logic [1:0]                    hdr;
    logic [`PCS_PAYLOAD_WIDTH-1:0] plain;
    logic [`PCS_PAYLOAD_WIDTH-1:0] scrambled;
    rx_pcs_pkg::rx_block_t         exp;
    r_kind = lcg_next();
    r_hi   = lcg_next();
    r_lo   = lcg_next();
    // Sequence number sits in the top 16 payload bits
    plain  = {seq, r_hi[31:16], r_lo};
    if (r_kind[31]) begin
      hdr      = 2'b10;
      exp.kind = rx_pcs_pkg::KIND_CTRL;
    end else begin
      hdr      = 2'b01;
      exp.kind = rx_pcs_pkg::KIND_DATA;
    end
    // Flipping the first header bit turns 01 into 00 and 10 into 11
    if (corrupt_left > 0) begin
      hdr          = hdr ^ 2'b01;
      exp.kind     = rx_pcs_pkg::KIND_ERROR;
      corrupt_left = corrupt_left - 1;
    end
    exp.payload = plain;
    // Self-synchronizing scrambler, history index 0 is the newest line bit
    for (int i = 0; i < `PCS_PAYLOAD_WIDTH; i++) begin
      scrambled[i] = plain[i] ^ scr_hist[`PCS_SCR_TAP_B-1] ^ scr_hist[`PCS_SCR_TAP_A-1];
      scr_hist     = {scr_hist[`PCS_SCR_TAP_A-2:0], scrambled[i]};
    end
    line_q.push_back(hdr[0]);
    line_q.push_back(hdr[1]);
    for (int i = 0; i < `PCS_PAYLOAD_WIDTH; i++) begin
      line_q.push_back(scrambled[i]);
    end
    exp_q.push_back(exp);
    seq        = seq + 16'd1;
    blocks_gen = blocks_gen + 1;
  endtask

  // Words leave a small delay after the rising edge, bit 0 first on the line
  initial begin
    rx_pcs_pkg::gt_word_t w;
    forever begin
      @(posedge gt0_rxusrclk2);
      #2;
      if (stream_on) begin
        for (int j = 0; j < `PCS_GT_WIDTH; j++) begin
          if (line_q.size() == 0) begin
            gen_block();
          end
          w[j] = line_q.pop_front();
        end
        gt_word = w;
      end else begin
        gt_word = '0;
      end
    end
  end

  // ==========================================================================
  // Compare tasks and output monitor
  // ==========================================================================

  task automatic check_block(input string name, input rx_pcs_pkg::rx_block_t got,
                             input rx_pcs_pkg::rx_block_t exp);
    if (got !== exp) begin
      block_errs++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_lock(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      lock_errs++;
      $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // First output after a lock finds its place in the queue by sequence number
  task automatic take_output(input rx_pcs_pkg::rx_block_t got);
    rx_pcs_pkg::rx_block_t exp;
    if (!aligned) begin
      while (exp_q.size() > 0 && exp_q[0].payload[63:48] != got.payload[63:48]) begin
        void'(exp_q.pop_front());
      end
      aligned = 1'b1;
    end
    if (exp_q.size() == 0) begin
      other_errs++;
      $display("Error at %0t: output block %h matches no block sent", $time, got);
    end else begin
      exp = exp_q.pop_front();
      check_block("rx_block_o", got, exp);
      checked++;
      if (exp.kind == rx_pcs_pkg::KIND_ERROR) begin
        err_kinds++;
      end
    end
  endtask

  initial begin
    forever begin
      @(negedge gt0_rxusrclk2);
      if (check_low) begin
        check_lock("block_lock_o", block_lock, 1'b0);
        check_lock("rx_valid_o", rx_valid, 1'b0);
      end
      if (expect_lock) begin
        check_lock("block_lock_o", block_lock, 1'b1);
      end
      // A valid block needs lock in the cycle before it
      if (rx_valid && !lock_prev) begin
        other_errs++;
        $display("Error at %0t: rx_valid_o came while block lock was low", $time);
      end
      if (rx_valid) begin
        take_output(rx_block);
      end
      // Blocks are lost while unlocked, so order restarts at the next lock
      if (lock_prev && !block_lock) begin
        aligned = 1'b0;
      end
      lock_prev = block_lock;
    end
  end

  // ==========================================================================
  // Sequence
  // ==========================================================================

  task automatic wait_blocks(input int n);
    int start;
    start = blocks_gen;
    while (blocks_gen - start < n) begin
      @(negedge gt0_rxusrclk2);
    end
  endtask

  // Wait for the lock flag to reach a level within a number of sent blocks
  task automatic wait_lock(input logic level, input int limit, input string what);
    int start;
    start = blocks_gen;
    while (block_lock !== level && blocks_gen - start <= limit) begin
      @(negedge gt0_rxusrclk2);
    end
    if (block_lock !== level) begin
      other_errs++;
      $display("Error at %0t: no %s within %0d blocks", $time, what, limit);
    end
  endtask

  initial begin
    logic [31:0] r_a;
    logic [31:0] r_b;
    int          offset;
    int          base;
    gt0_rxfsmresetdone = 1'b0;
    gt_word            = '0;
    lcg_state          = 32'ha929798e;
    seq                = '0;
    blocks_gen         = 0;
    corrupt_left       = 0;
    stream_on          = 1'b0;
    check_low          = 1'b1;
    expect_lock        = 1'b0;
    aligned            = 1'b0;
    lock_prev          = 1'b0;
    checked            = 0;
    err_kinds          = 0;
    block_errs         = 0;
    lock_errs          = 0;
    other_errs         = 0;
    repeat (RESET_CYCLES) @(posedge gt0_rxusrclk2);
    #2;
    gt0_rxfsmresetdone = 1'b1;
    // All-zero input never locks and delivers nothing
    repeat (ZERO_CYCLES) @(negedge gt0_rxusrclk2);
    check_low = 1'b0;
    // Random scrambler state and random bit offset ahead of the first block
    r_a      = lcg_next();
    r_b      = lcg_next();
    scr_hist = {r_a[25:0], r_b};
    r_a      = lcg_next();
    offset   = r_a[31:8] % 66;
    for (int k = 0; k < offset; k++) begin
      r_b = lcg_next();
      line_q.push_back(r_b[31]);
    end
    stream_on = 1'b1;
    wait_lock(1'b1, LOCK_WAIT, "initial lock");
    expect_lock = 1'b1;
    wait_blocks(CLEAN_RUN);
    if (checked == 0) begin
      other_errs++;
      $display("Error at %0t: no block came out after lock", $time);
    end
    // Fewer bad headers than the limit, each shows up as an error block
    base         = err_kinds;
    corrupt_left = SMALL_BAD;
    wait_blocks(SMALL_RUN);
    if (err_kinds - base != SMALL_BAD) begin
      other_errs++;
      $display("Error at %0t: %0d error blocks out, %0d headers corrupted",
               $time, err_kinds - base, SMALL_BAD);
    end
    // Long bad run drops lock, then the receiver must find the boundary again
    expect_lock  = 1'b0;
    corrupt_left = LARGE_BAD;
    wait_lock(1'b0, DROP_WAIT, "lock loss");
    base = checked;
    wait_lock(1'b1, LOCK_WAIT, "relock");
    expect_lock = 1'b1;
    wait_blocks(CLEAN_RUN);
    if (checked == base) begin
      other_errs++;
      $display("Error at %0t: no block came out after relock", $time);
    end
    $display("Errors: block %0d, lock %0d, other %0d", block_errs, lock_errs, other_errs);
    if (block_errs + lock_errs + other_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Bound on run time from the block budget of all phases
  initial begin
    #(WATCHDOG_TIME);
    $display("Error at %0t: watchdog expired before the tests ended", $time);
    $display("Errors: block %0d, lock %0d, other %0d", block_errs, lock_errs, other_errs);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* files.f */
+incdir+src
src/rx_pcs_pkg.sv
src/rx_gearbox.sv
src/sh_window_counter.sv
src/block_lock_fsm.sv
src/rx_descrambler.sv
src/rx_pcs_top.sv
bench/rx_pcs_chk.sv
bench/rx_pcs_tb.sv

/* Makefile */
# Verilator build and run of the receive PCS testbench

SIM := obj_dir/Vrx_pcs_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): files.f $(wildcard src/*.sv src/*.svh bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module rx_pcs_tb \
		-f files.f -o Vrx_pcs_tb

# Fails on the fail message, or when the pass message never appears
run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Simulation failed" sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
